// ==== rtl/osd_link_pkg.sv ====
// host link definitions; command code is byte bits 7:2, counter saturates at DAT_CNT_MAX
`default_nettype none

package osd_link_pkg;

  // --------------------------------------------------
  // link types
  // --------------------------------------------------
  typedef logic [7:0] osd_byte_t;
  typedef logic [5:0] cmd_code_t;
  typedef logic [2:0] dat_cnt_t;

  // counter stops here, later bytes all see this count
  localparam dat_cnt_t DAT_CNT_MAX = 3'd4;
  // address bytes ahead of the page byte under MEM_WRITE
  localparam dat_cnt_t HDR_BYTES   = 3'd3;

  // --------------------------------------------------
  // command codes, upper six bits of a command byte
  // --------------------------------------------------
  localparam cmd_code_t RESET_CTRL    = 6'b0_000_10;
  localparam cmd_code_t OSD_CTRL      = 6'b0_010_10;
  localparam cmd_code_t CHIP_CFG      = 6'b0_000_01;
  localparam cmd_code_t CPU_CFG       = 6'b0_001_01;
  localparam cmd_code_t MEMORY_CFG    = 6'b0_010_01;
  localparam cmd_code_t VIDEO_CFG     = 6'b0_011_01;
  localparam cmd_code_t FLOPPY_CFG    = 6'b0_100_01;
  localparam cmd_code_t HARDDISK0_CFG = 6'b0_101_01;
  localparam cmd_code_t HARDDISK1_CFG = 6'b0_101_10;
  localparam cmd_code_t JOYSTICK_CFG  = 6'b0_110_01;
  localparam cmd_code_t MEM_WRITE     = 6'b0_001_11;
  localparam cmd_code_t VERSION       = 6'b1_000_10;

  // --------------------------------------------------
  // version reply bytes, in reply order
  // --------------------------------------------------
  localparam osd_byte_t VER_BETA   = 8'h01;
  localparam osd_byte_t VER_MAJOR  = 8'h02;
  localparam osd_byte_t VER_MINOR  = 8'h05;
  // repeated for every count from 3 on
  localparam osd_byte_t VER_MINION = 8'h03;

endpackage

`default_nettype wire

// ==== rtl/osd_host_pkg.sv ====
// host bus and config field widths; defaults are the values seen right after reset
`default_nettype none

package osd_host_pkg;

  // --------------------------------------------------
  // host bus
  // --------------------------------------------------
  localparam int HOST_ADR_W = 24;
  localparam int HOST_DAT_W = 16;

  typedef logic [HOST_ADR_W-1:0] host_adr_t;
  typedef logic [HOST_DAT_W-1:0] host_dat_t;

  // --------------------------------------------------
  // config field widths and reset values
  // --------------------------------------------------
  localparam int CHIPSET_W = 5;
  localparam int CPU_W     = 4;
  localparam int MEMORY_W  = 7;
  localparam int FLOPPY_W  = 4;
  localparam int IDE_W     = 3;

  localparam logic [CHIPSET_W-1:0] CHIPSET_DEFAULT = '0;
  localparam logic [CPU_W-1:0]     CPU_DEFAULT     = '0;
  // fast 00, slow 01, chip 01
  localparam logic [MEMORY_W-1:0]  MEMORY_DEFAULT  = 7'b0000101;
  localparam logic [FLOPPY_W-1:0]  FLOPPY_DEFAULT  = '0;
  localparam logic [IDE_W-1:0]     IDE_DEFAULT     = '0;

endpackage

`default_nettype wire

// ==== rtl/osd_word_fifo.sv ====
// first-word-fall-through, depth 2**depth_log2 words; writing when full is a caller error
`default_nettype none

module osd_word_fifo import osd_host_pkg::*; #(
  parameter int depth_log2 = 2
) (
  input  wire       clk,
  input  wire       reset,
  input  wire       wr_en,
  input  host_dat_t wr_data,
  input  wire       rd_en,
  output host_dat_t rd_data,
  output logic      full,
  output logic      empty
);

  localparam int depth = 1 << depth_log2;

  host_dat_t mem [depth];
  // top bit marks the wrap
  logic [depth_log2:0] wr_ptr;
  logic [depth_log2:0] rd_ptr;

  // --------------------------------------------------
  // pointers
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[depth_log2-1:0]] <= wr_data;
    end
  end

  // head word always on the output
  assign rd_data = mem[rd_ptr[depth_log2-1:0]];
  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[depth_log2] != rd_ptr[depth_log2]) &&
                   (wr_ptr[depth_log2-1:0] == rd_ptr[depth_log2-1:0]);

  // link sender must watch fifo_full
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !full);
  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> !empty);

endmodule

`default_nettype wire

// ==== rtl/osd_mem_writer.sv ====
// one host write in flight; a command byte aborts the bus cycle but keeps the FIFO contents
`default_nettype none

module osd_mem_writer import osd_link_pkg::*; import osd_host_pkg::*; #(
  parameter int fifo_depth_log2 = 2
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        cmd_start,
  input  wire        mem_hdr_wr,
  input  wire [1:0]  mem_hdr_idx,
  input  wire        mem_dat_wr,
  input  osd_byte_t  byte_data,
  input  wire        host_ack,
  output logic       host_cs,
  output host_adr_t  host_adr,
  output host_dat_t  host_wdat,
  output logic       fifo_full
);

  typedef enum logic {
    ST_IDLE,
    ST_WRITE
  } wr_state_t;

  wr_state_t wr_state;
  host_adr_t mem_cnt;
  osd_byte_t mem_hi;
  logic      mem_toggle;
  logic      fifo_push;
  logic      fifo_pop;
  logic      fifo_empty;

  // --------------------------------------------------
  // byte pairing with the high byte first
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || cmd_start) begin
      mem_toggle <= 1'b0;
    end else if (mem_dat_wr) begin
      mem_toggle <= ~mem_toggle;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_dat_wr && !mem_toggle) begin
      mem_hi <= byte_data;
    end
  end

  // second byte of a pair completes the word
  assign fifo_push = mem_dat_wr && mem_toggle;

  osd_word_fifo #(
    .depth_log2 (fifo_depth_log2)
  ) osd_word_fifo_inst (
    .clk     (clk),
    .reset   (reset),
    .wr_en   (fifo_push),
    .wr_data ({mem_hi, byte_data}),
    .rd_en   (fifo_pop),
    .rd_data (host_wdat),
    .full    (fifo_full),
    .empty   (fifo_empty)
  );

  // --------------------------------------------------
  // address counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_cnt <= '0;
    end else if (mem_hdr_wr) begin
      // low byte arrives first
      case (mem_hdr_idx)
        2'd0:    mem_cnt[7:0] <= byte_data;
        2'd1:    mem_cnt[15:8] <= byte_data;
        default: mem_cnt[23:16] <= byte_data;
      endcase
    end else if (fifo_pop) begin
      mem_cnt <= mem_cnt + host_adr_t'(2);
    end
  end

  assign host_adr = mem_cnt;

  // --------------------------------------------------
  // host write FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset || cmd_start) begin
      wr_state <= ST_IDLE;
    end else begin
      case (wr_state)
        ST_IDLE:  if (!fifo_empty) wr_state <= ST_WRITE;
        ST_WRITE: if (host_ack) wr_state <= ST_IDLE;
        default:  wr_state <= ST_IDLE;
      endcase
    end
  end

  assign host_cs  = (wr_state == ST_WRITE);
  // head word leaves on the acknowledged edge
  assign fifo_pop = host_cs && host_ack;

  // address and data hold for the whole bus cycle
  a_cs_hold: assert property (@(posedge clk) disable iff (reset)
    (host_cs && !host_ack && !cmd_start) |=>
      (host_cs && $stable(host_adr) && $stable(host_wdat)));

endmodule

`default_nettype wire

// ==== rtl/osd_cmd_decode.sv ====
// expects framed bytes, one byte_valid pulse each; VERSION reply follows the count
`default_nettype none

module osd_cmd_decode import osd_link_pkg::*; (
  input  wire       clk,
  input  wire       reset,
  input  wire       byte_valid,
  input  wire       byte_is_cmd,
  input  osd_byte_t byte_data,
  input  osd_byte_t osd_ctrl,
  output logic      cmd_start,
  output logic      cfg_wr,
  output cmd_code_t cfg_code,
  output logic      mem_hdr_wr,
  output logic [1:0] mem_hdr_idx,
  output logic      mem_dat_wr,
  output osd_byte_t reply_data
);

  cmd_code_t cmd_dat;
  dat_cnt_t  dat_cnt;
  logic      dat_stb;
  logic      is_mem;

  // --------------------------------------------------
  // command latch and data byte counter
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_dat <= '0;
      dat_cnt <= '0;
    end else if (byte_valid && byte_is_cmd) begin
      cmd_dat <= byte_data[7:2];
      dat_cnt <= '0;
    end else if (byte_valid && dat_cnt != DAT_CNT_MAX) begin
      // saturate, memory data keeps count at max
      dat_cnt <= dat_cnt + 3'd1;
    end
  end

  assign dat_stb = byte_valid && !byte_is_cmd;
  assign is_mem  = (cmd_dat == MEM_WRITE);

  // --------------------------------------------------
  // strobes, at most one per data byte
  // --------------------------------------------------
  assign cmd_start   = byte_valid && byte_is_cmd;
  // first byte of everything but memory write
  assign cfg_wr      = dat_stb && !is_mem && (dat_cnt == '0);
  assign cfg_code    = cmd_dat;
  // address low, mid, high
  assign mem_hdr_wr  = dat_stb && is_mem && (dat_cnt < HDR_BYTES);
  assign mem_hdr_idx = dat_cnt[1:0];
  // count 3 is the page byte, dropped
  assign mem_dat_wr  = dat_stb && is_mem && (dat_cnt == DAT_CNT_MAX);

  // reply byte
  always_comb begin
    reply_data = osd_ctrl;
    if (cmd_dat == VERSION) begin
      case (dat_cnt)
        3'd0:    reply_data = VER_BETA;
        3'd1:    reply_data = VER_MAJOR;
        3'd2:    reply_data = VER_MINOR;
        default: reply_data = VER_MINION;
      endcase
    end
  end

  // link strobe must be clean once out of reset
  a_valid_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(byte_valid));

endmodule

`default_nettype wire

// ==== rtl/osd_cfg_regs.sv ====
// staged cpu/memory/chipset/ide fields only reach outputs while cpurst is high
`default_nettype none

module osd_cfg_regs import osd_link_pkg::*; import osd_host_pkg::*; (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        cfg_wr,
  input  cmd_code_t                  cfg_code,
  input  osd_byte_t                  byte_data,
  output logic                       osd_enable,
  output logic                       key_disable,
  output logic                       usrrst,
  output logic                       cpurst,
  output logic                       cpuhlt,
  output logic [CHIPSET_W-1:0]       chipset_config,
  output logic [CPU_W-1:0]           cpu_config,
  output logic [MEMORY_W-1:0]        memory_config,
  output logic [1:0]                 lr_filter,
  output logic [1:0]                 hr_filter,
  output logic [1:0]                 scanline,
  output logic [1:0]                 dither,
  output logic [FLOPPY_W-1:0]        floppy_config,
  output logic [IDE_W-1:0]           ide_config0,
  output logic [IDE_W-1:0]           ide_config1,
  output logic [1:0]                 autofire_config,
  output logic                       cd32pad
);

  // shadow copies, written straight from the link
  logic [CHIPSET_W-1:0] t_chipset_config;
  logic [CPU_W-1:0]     t_cpu_config;
  logic [MEMORY_W-1:0]  t_memory_config;
  logic [IDE_W-1:0]     t_ide_config0;
  logic [IDE_W-1:0]     t_ide_config1;

  // --------------------------------------------------
  // register writes, first data byte only
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      {cpuhlt, cpurst, usrrst} <= 3'b110;
      {key_disable, osd_enable} <= 2'b00;
      {dither, hr_filter, lr_filter, scanline} <= '0;
      floppy_config <= FLOPPY_DEFAULT;
      {cd32pad, autofire_config} <= 3'b000;
      t_chipset_config <= CHIPSET_DEFAULT;
      t_cpu_config <= CPU_DEFAULT;
      t_memory_config <= MEMORY_DEFAULT;
      t_ide_config0 <= IDE_DEFAULT;
      t_ide_config1 <= IDE_DEFAULT;
    end else if (cfg_wr) begin
      case (cfg_code)
        // halt, reset, user reset
        RESET_CTRL:    {cpuhlt, cpurst, usrrst} <= byte_data[2:0];
        // keyboard off, osd on
        OSD_CTRL:      {key_disable, osd_enable} <= byte_data[1:0];
        CHIP_CFG:      t_chipset_config <= byte_data[CHIPSET_W-1:0];
        CPU_CFG:       t_cpu_config <= byte_data[CPU_W-1:0];
        MEMORY_CFG:    t_memory_config <= byte_data[MEMORY_W-1:0];
        // two bits each, dither on top
        VIDEO_CFG:     {dither, hr_filter, lr_filter, scanline} <= byte_data;
        FLOPPY_CFG:    floppy_config <= byte_data[FLOPPY_W-1:0];
        HARDDISK0_CFG: t_ide_config0 <= byte_data[IDE_W-1:0];
        HARDDISK1_CFG: t_ide_config1 <= byte_data[IDE_W-1:0];
        JOYSTICK_CFG:  {cd32pad, autofire_config} <= byte_data[2:0];
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // shadow to output
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      chipset_config <= CHIPSET_DEFAULT;
      cpu_config <= CPU_DEFAULT;
      memory_config <= MEMORY_DEFAULT;
      ide_config0 <= IDE_DEFAULT;
      ide_config1 <= IDE_DEFAULT;
    end else begin
      // cache/kickstart and hrtmon bits track at once
      cpu_config[CPU_W-1:2] <= t_cpu_config[CPU_W-1:2];
      memory_config[MEMORY_W-1] <= t_memory_config[MEMORY_W-1];
      // the rest waits for the cpu to sit in reset
      if (cpurst) begin
        chipset_config <= t_chipset_config;
        cpu_config[1:0] <= t_cpu_config[1:0];
        memory_config[MEMORY_W-2:0] <= t_memory_config[MEMORY_W-2:0];
        ide_config0 <= t_ide_config0;
        ide_config1 <= t_ide_config1;
      end
    end
  end

  // decoder hands over a defined code with every write strobe
  a_code_known: assert property (@(posedge clk) disable iff (reset)
    cfg_wr |-> !$isunknown(cfg_code));

endmodule

`default_nettype wire

// ==== rtl/osd_ctrl_top.sv ====
// command side only: byte stream must arrive framed, no OSD video, all logic on every clk
`default_nettype none

module osd_ctrl_top import osd_link_pkg::*; import osd_host_pkg::*; #(
  parameter int fifo_depth_log2 = 2
) (
  input  wire                  clk,
  input  wire                  reset,
  // host link
  input  wire                  byte_valid,
  input  wire                  byte_is_cmd,
  input  osd_byte_t            byte_data,
  input  osd_byte_t            osd_ctrl,
  output osd_byte_t            reply_data,
  // configuration
  output logic                 osd_enable,
  output logic                 key_disable,
  output logic                 usrrst,
  output logic                 cpurst,
  output logic                 cpuhlt,
  output logic [CHIPSET_W-1:0] chipset_config,
  output logic [CPU_W-1:0]     cpu_config,
  output logic [MEMORY_W-1:0]  memory_config,
  output logic [1:0]           lr_filter,
  output logic [1:0]           hr_filter,
  output logic [1:0]           scanline,
  output logic [1:0]           dither,
  output logic [FLOPPY_W-1:0]  floppy_config,
  output logic [IDE_W-1:0]     ide_config0,
  output logic [IDE_W-1:0]     ide_config1,
  output logic [1:0]           autofire_config,
  output logic                 cd32pad,
  // host bus
  output logic                 host_cs,
  output host_adr_t            host_adr,
  output host_dat_t            host_wdat,
  input  wire                  host_ack,
  output logic                 fifo_full
);

  // --------------------------------------------------
  // decoder strobes
  // --------------------------------------------------
  logic      cmd_start;
  logic      cfg_wr;
  cmd_code_t cfg_code;
  logic      mem_hdr_wr;
  logic [1:0] mem_hdr_idx;
  logic      mem_dat_wr;

  osd_cmd_decode osd_cmd_decode_inst (
    .clk         (clk),
    .reset       (reset),
    .byte_valid  (byte_valid),
    .byte_is_cmd (byte_is_cmd),
    .byte_data   (byte_data),
    .osd_ctrl    (osd_ctrl),
    .cmd_start   (cmd_start),
    .cfg_wr      (cfg_wr),
    .cfg_code    (cfg_code),
    .mem_hdr_wr  (mem_hdr_wr),
    .mem_hdr_idx (mem_hdr_idx),
    .mem_dat_wr  (mem_dat_wr),
    .reply_data  (reply_data)
  );

  osd_cfg_regs osd_cfg_regs_inst (
    .clk             (clk),
    .reset           (reset),
    .cfg_wr          (cfg_wr),
    .cfg_code        (cfg_code),
    .byte_data       (byte_data),
    .osd_enable      (osd_enable),
    .key_disable     (key_disable),
    .usrrst          (usrrst),
    .cpurst          (cpurst),
    .cpuhlt          (cpuhlt),
    .chipset_config  (chipset_config),
    .cpu_config      (cpu_config),
    .memory_config   (memory_config),
    .lr_filter       (lr_filter),
    .hr_filter       (hr_filter),
    .scanline        (scanline),
    .dither          (dither),
    .floppy_config   (floppy_config),
    .ide_config0     (ide_config0),
    .ide_config1     (ide_config1),
    .autofire_config (autofire_config),
    .cd32pad         (cd32pad)
  );

  // memory write path
  osd_mem_writer #(
    .fifo_depth_log2 (fifo_depth_log2)
  ) osd_mem_writer_inst (
    .clk         (clk),
    .reset       (reset),
    .cmd_start   (cmd_start),
    .mem_hdr_wr  (mem_hdr_wr),
    .mem_hdr_idx (mem_hdr_idx),
    .mem_dat_wr  (mem_dat_wr),
    .byte_data   (byte_data),
    .host_ack    (host_ack),
    .host_cs     (host_cs),
    .host_adr    (host_adr),
    .host_wdat   (host_wdat),
    .fifo_full   (fifo_full)
  );

endmodule

`default_nettype wire

// ==== bench/osd_ctrl_tb.sv ====
// runs from the project root; the fill case expects fifo_depth_log2 = 2 (4 words)
`default_nettype none

module osd_ctrl_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // cycle budget per line of the input file
  localparam int CYCLES_PER_OP = 40;

  logic        clk = 1'b0;
  logic        reset;
  logic        byte_valid;
  logic        byte_is_cmd;
  logic [7:0]  byte_data;
  logic [7:0]  osd_ctrl;
  logic        host_ack = 1'b0;
  logic [7:0]  reply_data;
  logic        osd_enable;
  logic        key_disable;
  logic        usrrst;
  logic        cpurst;
  logic        cpuhlt;
  logic [4:0]  chipset_config;
  logic [3:0]  cpu_config;
  logic [6:0]  memory_config;
  logic [1:0]  lr_filter;
  logic [1:0]  hr_filter;
  logic [1:0]  scanline;
  logic [1:0]  dither;
  logic [3:0]  floppy_config;
  logic [2:0]  ide_config0;
  logic [2:0]  ide_config1;
  logic [1:0]  autofire_config;
  logic        cd32pad;
  logic        host_cs;
  logic [23:0] host_adr;
  logic [15:0] host_wdat;
  logic        fifo_full;

  // operations from the input file, in file order
  logic [7:0]  op_kind[$];
  logic [31:0] op_a[$];
  logic [31:0] op_b[$];
  // expected host writes, address over data
  logic [39:0] exp_q[$];

  logic [31:0] lfsr_state = 32'hb77b4ce2;
  logic        ack_hold = 1'b0;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;

  osd_ctrl_top #(
    .fifo_depth_log2 (2)
  ) osd_ctrl_top_inst (.*);

  always #20 clk = ~clk;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic take_bit();
    logic bit_out;
    bit_out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out) lfsr_state = lfsr_state ^ 32'h80200003;
    return bit_out;
  endfunction

  function automatic logic [1:0] ack_delay();
    logic [1:0] d;
    d[0] = take_bit();
    d[1] = take_bit();
    return d;
  endfunction

  // field index as used in the F column of the input file
  function automatic logic [31:0] field_value(input logic [31:0] idx);
    case (idx)
      32'h00:  return 32'(osd_enable);
      32'h01:  return 32'(key_disable);
      32'h02:  return 32'(usrrst);
      32'h03:  return 32'(cpurst);
      32'h04:  return 32'(cpuhlt);
      32'h05:  return 32'(chipset_config);
      32'h06:  return 32'(cpu_config);
      32'h07:  return 32'(memory_config);
      32'h08:  return 32'(lr_filter);
      32'h09:  return 32'(hr_filter);
      32'h0a:  return 32'(scanline);
      32'h0b:  return 32'(dither);
      32'h0c:  return 32'(floppy_config);
      32'h0d:  return 32'(ide_config0);
      32'h0e:  return 32'(ide_config1);
      32'h0f:  return 32'(autofire_config);
      32'h10:  return 32'(cd32pad);
      32'h11:  return 32'(host_cs);
      32'h12:  return 32'(fifo_full);
      default: return 'x;
    endcase
  endfunction

  // one byte on the link, valid for a single clk
  task automatic send_byte(input logic is_cmd, input logic [7:0] value);
    @(negedge clk);
    // sender holds memory data back while the FIFO is full
    while (!is_cmd && fifo_full) @(negedge clk);
    byte_valid = 1'b1;
    byte_is_cmd = is_cmd;
    byte_data = value;
    @(negedge clk);
    byte_valid = 1'b0;
    byte_is_cmd = 1'b0;
  endtask

  task automatic run_op(input logic [7:0] kind, input logic [31:0] arg_a,
                        input logic [31:0] arg_b);
    logic [31:0] got;
    case (kind)
      "C": send_byte(1'b1, arg_a[7:0]);
      "D": send_byte(1'b0, arg_a[7:0]);
      "R": begin
        @(negedge clk);
        assert (reply_data == arg_a[7:0]) else stop_on_error($sformatf(
          "** Error at %0t: reply %h, expected %h", $time, reply_data, arg_a[7:0]));
      end
      "F": begin
        @(negedge clk);
        got = field_value(arg_a);
        assert (got == arg_b) else stop_on_error($sformatf(
          "** Error at %0t: field %0h is %0h, expected %0h", $time, arg_a, got, arg_b));
      end
      "P": begin
        @(negedge clk);
        assert (cpurst == arg_a[0]) else stop_on_error($sformatf(
          "** Error at %0t: cpurst %b, expected %b", $time, cpurst, arg_a[0]));
      end
      "W": exp_q.push_back({arg_a[23:0], arg_b[15:0]});
      "H": ack_hold = arg_a[0];
      // wait until no more than arg_a writes are outstanding
      "Q": while (exp_q.size() > arg_a) @(negedge clk);
      default: stop_on_error($sformatf("unknown operation %s in the input file", kind));
    endcase
  endtask

  // --------------------------------------------------
  // host bus model, random acknowledge delay
  // --------------------------------------------------
  always begin
    logic [1:0] delay;
    @(negedge clk);
    host_ack = 1'b0;
    if (!reset && host_cs && !ack_hold) begin
      delay = ack_delay();
      repeat (delay) @(negedge clk);
      if (host_cs && !ack_hold) begin
        assert (exp_q.size() > 0) else stop_on_error("host write seen with none expected");
        assert ({host_adr, host_wdat} == exp_q[0]) else stop_on_error($sformatf(
          "** Error at %0t: host write %h=%h, expected %h=%h", $time, host_adr,
          host_wdat, exp_q[0][39:16], exp_q[0][15:0]));
        void'(exp_q.pop_front());
        // write completes at the next rising edge
        host_ack = 1'b1;
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      stop_on_error($sformatf("run hung, still busy after %0d cycles", cycle_cnt));
    end
  end

  // --------------------------------------------------
  // load the input file, then run it
  // --------------------------------------------------
  initial begin
    int fd;
    int code;
    int c;
    logic [7:0]  kind;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    reset = 1'b1;
    byte_valid = 1'b0;
    byte_is_cmd = 1'b0;
    byte_data = 8'h00;
    // keycode returned outside VERSION
    osd_ctrl = 8'h5a;
    fd = $fopen("bench/osd_ctrl_tb_input.txt", "r");
    if (fd == 0) stop_on_error("cannot open bench/osd_ctrl_tb_input.txt");
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code == 1) begin
        arg_b = '0;
        if (kind == "#") begin
          // comment line, skip to its end
          c = $fgetc(fd);
          while (c != 10 && c != -1) c = $fgetc(fd);
        end else begin
          if (kind == "F" || kind == "W") code = $fscanf(fd, "%h %h", arg_a, arg_b);
          else code = $fscanf(fd, "%h", arg_a);
          if (code < 1) stop_on_error("malformed line in the input file");
          op_kind.push_back(kind);
          op_a.push_back(arg_a);
          op_b.push_back(arg_b);
        end
      end
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_OP * op_kind.size();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    foreach (op_kind[i]) run_op(op_kind[i], op_a[i], op_b[i]);
    if (exp_q.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      stop_on_error($sformatf("%0d expected host writes never happened", exp_q.size()));
    end
  end

endmodule

`default_nettype wire

// ==== bench/osd_ctrl_tb_input.txt ====
# op arg [arg], hex: C cmd byte, D data byte, R reply, F field value, W host write adr dat
# P cpurst level, H hold acks 1/0, Q wait until at most n writes outstanding
# fields: 00 osd_en 01 key_dis 02 usrrst 03 cpurst 04 cpuhlt 05 chipset 06 cpu 07 memory
# 08 lr 09 hr 0a scanline 0b dither 0c floppy 0d ide0 0e ide1 0f autofire 10 cd32 11 cs 12 full
# defaults after reset
F 00 0
F 01 0
F 02 0
P 1
F 04 1
F 05 00
F 06 0
F 07 05
F 08 0
F 0b 0
F 0c 0
F 0d 0
F 0e 0
F 0f 0
F 10 0
F 11 0
F 12 0
R 5a
# osd control, later bytes ignored
C 28
D 03
F 00 1
F 01 1
D 00
F 00 1
R 5a
# video dither hr lr scanline
C 34
D 9c
F 0b 2
F 09 1
F 08 3
F 0a 0
D 00
F 0b 2
C 44
D 0a
F 0c a
# joystick cd32pad autofire
C 64
D 06
F 10 1
F 0f 2
C 08
D 07
F 02 1
P 1
# staged fields with cpu in reset
C 04
D 15
F 05 15
C 54
D 05
F 0d 5
C 58
D 03
F 0e 3
C 14
D 02
F 06 2
C 24
D 0c
F 07 0c
# cpu out of reset, staged fields wait
C 08
D 00
P 0
F 04 0
F 02 0
C 04
D 0a
F 05 15
C 54
D 02
F 0d 5
C 58
D 06
F 0e 3
C 14
D 0d
F 06 e
C 24
D 6a
F 07 4c
C 08
D 06
P 1
F 05 0a
F 0d 2
F 0e 6
F 06 d
F 07 6a
# version bytes
C 88
R 01
D 00
R 02
D 00
R 05
D 00
R 03
D 00
R 03
C 28
R 5a
# memory write at 021000, page 7f
W 021000 a1b2
W 021002 c3d4
W 021004 e5f6
W 021006 0718
W 021008 293a
C 1c
D 00
D 10
D 02
D 7f
D a1
D b2
D c3
D d4
D e5
D f6
D 07
D 18
D 29
D 3a
Q 0
W 12feff 5566
W 12ff01 7788
C 1c
D ff
D fe
D 12
D 00
D 55
D 66
D 77
D 88
Q 0
# fill the FIFO with acks held
H 1
W 002000 0102
W 002002 0304
W 002004 0506
W 002006 0708
C 1c
D 00
D 20
D 00
D 00
D 01
D 02
D 03
D 04
D 05
D 06
D 07
D 08
F 12 1
F 11 1
H 0
Q 3
F 12 0
Q 0
F 11 0

// ==== vlog.f ====
rtl/osd_link_pkg.sv
rtl/osd_host_pkg.sv
rtl/osd_word_fifo.sv
rtl/osd_mem_writer.sv
rtl/osd_cmd_decode.sv
rtl/osd_cfg_regs.sv
rtl/osd_ctrl_top.sv
bench/osd_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module osd_ctrl_tb -f vlog.f -o osd_ctrl_sim

# a failing run still leaves its log for the search below
./obj_dir/osd_ctrl_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
grep -q "sim passed" sim.log
